// File: filelist.f
z80_bus_pkg.sv
z80_isa_pkg.sv
reg_port_if.sv
z80_register_file.sv
z80_instr_decoder.sv
z80_sequencer.sv
z80_core.sv
tb_z80_core.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_z80_core \
    -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_z80_core
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi
exit 0

// File: tb_z80_core.sv
module tb_z80_core;

    localparam z80_bus_pkg::addr_t RESET_PC     = 16'h0000;
    localparam z80_bus_pkg::byte_t DATA_HI      = 8'h80; // data region at 0x8000
    localparam int                 NUM_RANDOM   = 120;
    localparam int                 RESET_CYCLES = 5;
    localparam int                 DRIVE_DLY    = 2;
    localparam z80_bus_pkg::byte_t NOP_OPS [8]  = '{8'h00, 8'h76, 8'h46, 8'h7E,
                                                    8'h03, 8'hC3, 8'hED, 8'hFF};

    logic               clk;
    logic               reset;
    z80_bus_pkg::byte_t i_mem_data;
    z80_bus_pkg::addr_t o_addr;
    logic               o_read_mem;
    logic               o_write_mem;
    z80_bus_pkg::byte_t o_write_data;
    logic               o_done;

    z80_bus_pkg::byte_t mem [65536];   // what the DUT sees
    z80_bus_pkg::byte_t m_mem [65536]; // reference copy
    z80_bus_pkg::byte_t m_regs [8];    // B C D E H L - A
    z80_bus_pkg::addr_t model_pc;
    z80_bus_pkg::addr_t gen_pc;
    integer             seed;
    int                 n_insns;
    int                 insn_idx;
    int                 cycle_cnt;
    int                 done_cycle;
    int                 exp_cycles;
    int                 errors;
    logic               exp_wr;
    z80_bus_pkg::addr_t exp_wa;
    z80_bus_pkg::byte_t exp_wd;
    logic               wr_seen;
    logic               all_done;
    logic               bus_wr;
    z80_bus_pkg::addr_t bus_wa;
    z80_bus_pkg::byte_t bus_wd;

    z80_core #(
        .RESET_PC (RESET_PC)
    ) dut0 (
        .clk          (clk),
        .reset        (reset),
        .i_mem_data   (i_mem_data),
        .o_addr       (o_addr),
        .o_read_mem   (o_read_mem),
        .o_write_mem  (o_write_mem),
        .o_write_data (o_write_data),
        .o_done       (o_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_mismatch(input string what);
        errors++;
        $display("FAIL at time %0t: %s", $time, what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("Error at time %0t: %s", $time, what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic next_random(output logic [31:0] r);
        r = $random(seed);
    endtask

    task automatic emit_insn(input int len, input z80_bus_pkg::byte_t b0,
                             input z80_bus_pkg::byte_t b1, input z80_bus_pkg::byte_t b2);
        mem[gen_pc] = b0;
        mem[gen_pc + 16'd1] = b1; // spare bytes get overwritten by the next insn
        mem[gen_pc + 16'd2] = b2;
        gen_pc = gen_pc + z80_bus_pkg::addr_t'(len);
        n_insns++;
    endtask

    function automatic z80_bus_pkg::word_t pair_value(input logic [1:0] p);
        return {m_regs[{p, 1'b0}], m_regs[{p, 1'b1}]};
    endfunction

    // one instruction on the reference model, from the Z80 load rules
    function automatic void model_step(input z80_bus_pkg::addr_t pc, output int len,
                                       output int cyc, output logic wr,
                                       output z80_bus_pkg::addr_t wa,
                                       output z80_bus_pkg::byte_t wd);
        z80_bus_pkg::byte_t op;
        z80_bus_pkg::word_t nn;
        logic [2:0]         d;
        logic [2:0]         s;
        op = m_mem[pc];
        nn = {m_mem[pc + 16'd2], m_mem[pc + 16'd1]};
        d = op[5:3];
        s = op[2:0];
        len = 1;
        cyc = 1;
        wr = 1'b0;
        wa = pair_value(2'd2); // HL for the (HL) forms
        wd = m_regs[s];
        if (op[7:6] == 2'b01 && s != 3'd6 && d != 3'd6) begin
            m_regs[d] = m_regs[s];
        end else if (op[7:6] == 2'b01 && s != 3'd6) begin
            wr = 1'b1;
            cyc = 2;
        end else if (op[7:6] == 2'b00 && s == 3'd6) begin
            len = 2;
            cyc = (d == 3'd6) ? 3 : 2;
            wr = (d == 3'd6);
            wd = nn[7:0];
            if (d != 3'd6)
                m_regs[d] = nn[7:0];
        end else if (op[7:6] == 2'b00 && op[3:0] == 4'b0001) begin
            len = 3;
            cyc = 3;
            // SP load has no way back onto the bus
            if (op[5:4] != 2'd3) begin
                m_regs[{op[5:4], 1'b0}] = nn[15:8];
                m_regs[{op[5:4], 1'b1}] = nn[7:0];
            end
        end else begin
            case (op)
                8'h02, 8'h12: begin
                    wr = 1'b1;
                    cyc = 2;
                    wa = pair_value({1'b0, op[4]});
                    wd = m_regs[7];
                end
                8'h0A, 8'h1A: begin
                    cyc = 2;
                    m_regs[7] = m_mem[pair_value({1'b0, op[4]})];
                end
                8'h32: begin
                    len = 3;
                    cyc = 4;
                    wr = 1'b1;
                    wa = nn;
                    wd = m_regs[7];
                end
                8'h3A: begin
                    len = 3;
                    cyc = 4;
                    m_regs[7] = m_mem[nn];
                end
                default: ; // one-byte nop
            endcase
        end
        if (wr)
            m_mem[wa] = wd;
    endfunction

    // B, D and H always keep bit 7 set so every store lands above the program
    task automatic gen_program();
        logic [31:0]        r1;
        logic [31:0]        r2;
        logic [2:0]         d;
        logic [2:0]         s;
        logic               high_dst;
        z80_bus_pkg::byte_t n;
        gen_pc = RESET_PC;
        n_insns = 0;
        for (int p = 0; p < 3; p++) begin
            next_random(r1);
            emit_insn(3, {2'b00, p[1:0], 4'b0001}, r1[7:0], DATA_HI);
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            next_random(r1);
            next_random(r2);
            s = (r2[2:0] == 3'd6) ? 3'd7 : r2[2:0];
            d = (r2[5:3] == 3'd6) ? 3'd7 : r2[5:3];
            n = r2[15:8];
            high_dst = (d == 3'd0 || d == 3'd2 || d == 3'd4);
            case (r1 % 12)
                0, 1: begin
                    if (high_dst)
                        s = {(r2[17:16] == 2'd3) ? 2'd0 : r2[17:16], 1'b0};
                    emit_insn(1, {2'b01, d, s}, 8'h00, 8'h00);
                end
                2, 3: begin
                    if (high_dst)
                        n[7] = 1'b1;
                    emit_insn(2, {2'b00, d, 3'b110}, n, 8'h00);
                end
                4: emit_insn(2, 8'h36, n, 8'h00);
                5: emit_insn(1, {5'b01110, s}, 8'h00, 8'h00);
                6: emit_insn(1, r2[16] ? 8'h12 : 8'h02, 8'h00, 8'h00);
                7: emit_insn(1, r2[16] ? 8'h1A : 8'h0A, 8'h00, 8'h00);
                8: emit_insn(3, {2'b00, r2[19:18], 4'b0001}, n,
                             (r2[19:18] == 2'd3) ? r2[27:20] : DATA_HI);
                9: emit_insn(3, 8'h3A, n, DATA_HI);
                10: emit_insn(3, 8'h32, n, DATA_HI);
                default: emit_insn(1, NOP_OPS[r2[18:16]], 8'h00, 8'h00);
            endcase
        end
        // store every register so earlier loads show up on the bus
        for (int r = 0; r < 8; r++) begin
            if (r != 6)
                emit_insn(1, {5'b01110, r[2:0]}, 8'h00, 8'h00);
        end
        next_random(r1);
        emit_insn(3, 8'h32, r1[7:0], DATA_HI);
    endtask

    // memory model, write lands at the edge that ends the write cycle
    always @(negedge clk) begin
        bus_wr <= (reset === 1'b0) && o_write_mem;
        bus_wa <= o_addr;
        bus_wd <= o_write_data;
    end

    always @(posedge clk) begin
        if (bus_wr === 1'b1)
            mem[bus_wa] = bus_wd;
        #DRIVE_DLY;
        i_mem_data = mem[o_addr];
    end

    // compare process, sampled mid cycle
    always @(negedge clk) begin
        int len;
        int cyc;
        if (reset === 1'b0 && !all_done) begin
            cycle_cnt++;
            // every step either fetches a byte or stores one
            assert (o_read_mem != o_write_mem)
                else report_error("read and write strobes are both high or both low");
            if (o_write_mem) begin
                assert (exp_wr && !wr_seen)
                    else report_error($sformatf("memory write to %h that no instruction makes",
                                                o_addr));
                assert (o_addr == exp_wa && o_write_data == exp_wd)
                    else report_mismatch($sformatf("write %h <= %h, expected %h <= %h",
                                                   o_addr, o_write_data, exp_wa, exp_wd));
                assert (cycle_cnt - done_cycle == exp_cycles - 1)
                    else report_error("memory write is not in the last cycle of its instruction");
                wr_seen = 1'b1;
            end
            if (o_done) begin
                if (insn_idx > 0) begin
                    assert (cycle_cnt - done_cycle == exp_cycles)
                        else report_mismatch($sformatf("insn %0d took %0d cycles, expected %0d",
                                                       insn_idx - 1, cycle_cnt - done_cycle,
                                                       exp_cycles));
                    assert (wr_seen || !exp_wr)
                        else report_error("an expected memory write never appeared");
                end
                assert (o_addr == model_pc)
                    else report_mismatch($sformatf("opcode fetch at %h, expected %h",
                                                   o_addr, model_pc));
                if (insn_idx == n_insns) begin
                    all_done = 1'b1;
                end else begin
                    model_step(model_pc, len, cyc, exp_wr, exp_wa, exp_wd);
                    model_pc = model_pc + z80_bus_pkg::addr_t'(len);
                    exp_cycles = cyc;
                    wr_seen = 1'b0;
                    done_cycle = cycle_cnt;
                    insn_idx++;
                end
            end
        end
    end

    initial begin
        reset = 1'b1;
        i_mem_data = '0;
        seed = 32'h9a536958;
        errors = 0;
        all_done = 1'b0;
        insn_idx = 0;
        cycle_cnt = 0;
        done_cycle = 0;
        exp_cycles = 0;
        model_pc = RESET_PC;
        for (int a = 0; a < 65536; a++)
            mem[a] = z80_bus_pkg::byte_t'(a[15:8] ^ {a[3:0], a[7:4]} ^ 8'h3C);
        gen_program();
        m_mem = mem;
        m_regs = '{default: 8'h00};
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;
        @(negedge clk);
        assert (o_done && o_read_mem && !o_write_mem && o_addr == RESET_PC)
            else report_mismatch($sformatf("after reset done %b read %b write %b addr %h",
                                           o_done, o_read_mem, o_write_mem, o_addr));
        wait (all_done);
        if (errors == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1);
        end
    end

    // watchdog, worst case is 4 cycles per instruction
    initial begin
        @(negedge reset);
        repeat (4 * n_insns + 50) @(posedge clk);
        $display("Watchdog expired after %0d of %0d instructions", insn_idx, n_insns);
        $display("Simulation failed");
        $fatal(1);
    end

endmodule

// File: z80_core.sv
module z80_core #(
    parameter z80_bus_pkg::addr_t RESET_PC = '0
) (
    input  logic               clk,
    input  logic               reset,
    input  z80_bus_pkg::byte_t i_mem_data,
    output z80_bus_pkg::addr_t o_addr,
    output logic               o_read_mem,
    output logic               o_write_mem,
    output z80_bus_pkg::byte_t o_write_data,
    output logic               o_done
);

    z80_bus_pkg::byte_t       opcode;
    z80_isa_pkg::insn_group_t group;

    reg_port_if rp ();

    z80_register_file u_regs (
        .clk   (clk),
        .reset (reset),
        .rp    (rp.rf)
    );

    z80_instr_decoder u_dec (
        .i_opcode (opcode),
        .o_group  (group)
    );

    z80_sequencer #(
        .RESET_PC (RESET_PC)
    ) u_seq (
        .clk          (clk),
        .reset        (reset),
        .i_mem_data   (i_mem_data),
        .i_group      (group),
        .o_opcode     (opcode),
        .o_addr       (o_addr),
        .o_read_mem   (o_read_mem),
        .o_write_mem  (o_write_mem),
        .o_write_data (o_write_data),
        .o_done       (o_done),
        .rp           (rp.seq)
    );

endmodule

// File: z80_sequencer.sv
module z80_sequencer #(
    parameter z80_bus_pkg::addr_t RESET_PC = '0
) (
    input  logic                     clk,
    input  logic                     reset,
    input  z80_bus_pkg::byte_t       i_mem_data,
    input  z80_isa_pkg::insn_group_t i_group,
    output z80_bus_pkg::byte_t       o_opcode,
    output z80_bus_pkg::addr_t       o_addr,
    output logic                     o_read_mem,
    output logic                     o_write_mem,
    output z80_bus_pkg::byte_t       o_write_data,
    output logic                     o_done,
    reg_port_if.seq                  rp
);

    z80_isa_pkg::seq_state_t state;
    z80_isa_pkg::seq_state_t next_state;
    z80_bus_pkg::byte_t      opcode_q;
    z80_bus_pkg::addr_t      scratch_addr;      // next pc or operand address
    z80_bus_pkg::addr_t      next_scratch_addr;
    z80_bus_pkg::byte_t      scratch_data;      // low byte of nn
    z80_bus_pkg::byte_t      next_scratch_data;

    z80_bus_pkg::addr_t      next_addr;
    logic                    next_read_mem;
    logic                    next_write_mem;
    z80_bus_pkg::byte_t      next_write_data;
    logic                    next_done;

    z80_isa_pkg::reg_sel_t   op_dst;
    z80_isa_pkg::reg_sel_t   op_src;
    z80_isa_pkg::reg_sel_t   op_dd;
    z80_isa_pkg::reg_sel_t   op_bcde;

    // opcode is live on the bus only in its own step
    assign o_opcode = (state == z80_isa_pkg::ST_OP) ? i_mem_data : opcode_q;

    assign op_dst  = {1'b0, o_opcode[z80_isa_pkg::OP_DST_HI:z80_isa_pkg::OP_DST_LO]};
    assign op_src  = {1'b0, o_opcode[z80_isa_pkg::OP_SRC_HI:z80_isa_pkg::OP_SRC_LO]};
    assign op_dd   = {2'b10, o_opcode[z80_isa_pkg::OP_DD_HI:z80_isa_pkg::OP_DD_LO]};
    assign op_bcde = o_opcode[z80_isa_pkg::OP_DE_BIT] ? z80_isa_pkg::REG_DE
                                                       : z80_isa_pkg::REG_BC;

    always_comb begin
        next_state        = z80_isa_pkg::ST_OP;
        next_scratch_addr = scratch_addr;
        next_scratch_data = scratch_data;
        next_addr         = o_addr;
        next_read_mem     = 1'b0;
        next_write_mem    = 1'b0;
        next_write_data   = '0;
        next_done         = 1'b0;
        rp.rd_sel1        = z80_isa_pkg::REG_A;
        rp.rd_sel2        = z80_isa_pkg::REG_A;
        rp.wr_en          = 1'b0;
        rp.wr_sel         = z80_isa_pkg::REG_A;
        rp.wr_data        = '0;

        // final step of every instruction, fetch opcode at next_addr
        if (state == z80_isa_pkg::ST_OP && (i_group == z80_isa_pkg::GRP_NOP ||
                                            i_group == z80_isa_pkg::GRP_LD_REG_REG)) begin
            next_done = 1'b1;
            next_addr = o_addr + 16'd1;
        end else if (state == z80_isa_pkg::ST_OP) begin
            next_state = z80_isa_pkg::ST_1;
        end

        case (i_group)
            z80_isa_pkg::GRP_LD_REG_REG: begin
                rp.rd_sel1 = op_src;
                rp.wr_en   = 1'b1;
                rp.wr_sel  = op_dst;
                rp.wr_data = {8'h00, rp.rd_data1[7:0]};
            end
            z80_isa_pkg::GRP_LD_REG_IMMED, z80_isa_pkg::GRP_LD_DD_IMMED,
            z80_isa_pkg::GRP_LD_HL_IMMED, z80_isa_pkg::GRP_LD_A_EXTADDR,
            z80_isa_pkg::GRP_LD_EXTADDR_A: begin
                case (state)
                    z80_isa_pkg::ST_OP: begin
                        next_addr = o_addr + 16'd1; // operand byte
                    end
                    z80_isa_pkg::ST_1: begin
                        next_state = z80_isa_pkg::ST_2;
                        next_addr  = o_addr + 16'd1;
                        next_scratch_data = i_mem_data;
                        if (i_group == z80_isa_pkg::GRP_LD_REG_IMMED) begin
                            rp.wr_en   = 1'b1;
                            rp.wr_sel  = op_dst;
                            rp.wr_data = {8'h00, i_mem_data};
                            next_state = z80_isa_pkg::ST_OP;
                            next_done  = 1'b1;
                        end else if (i_group == z80_isa_pkg::GRP_LD_HL_IMMED) begin
                            rp.rd_sel1        = z80_isa_pkg::REG_HL;
                            next_scratch_addr = o_addr + 16'd1;
                            next_addr         = rp.rd_data1;
                            next_write_mem    = 1'b1;
                            next_write_data   = i_mem_data;
                        end
                    end
                    z80_isa_pkg::ST_2: begin
                        next_addr = o_addr + 16'd1;
                        if (i_group == z80_isa_pkg::GRP_LD_HL_IMMED) begin
                            next_addr  = scratch_addr;
                            next_state = z80_isa_pkg::ST_OP;
                            next_done  = 1'b1;
                        end else if (i_group == z80_isa_pkg::GRP_LD_DD_IMMED) begin
                            rp.wr_en   = 1'b1;
                            rp.wr_sel  = op_dd;
                            rp.wr_data = {i_mem_data, scratch_data};
                            next_state = z80_isa_pkg::ST_OP;
                            next_done  = 1'b1;
                        end else begin
                            next_scratch_addr = o_addr + 16'd1;
                            next_addr  = {i_mem_data, scratch_data};
                            next_state = z80_isa_pkg::ST_3;
                            rp.rd_sel1 = z80_isa_pkg::REG_A;
                            next_write_mem  = (i_group == z80_isa_pkg::GRP_LD_EXTADDR_A);
                            next_write_data = rp.rd_data1[7:0];
                        end
                    end
                    default: begin
                        next_addr = scratch_addr;
                        next_done = 1'b1;
                        if (i_group == z80_isa_pkg::GRP_LD_A_EXTADDR) begin
                            rp.wr_en   = 1'b1;
                            rp.wr_sel  = z80_isa_pkg::REG_A;
                            rp.wr_data = {8'h00, i_mem_data};
                        end
                    end
                endcase
            end
            z80_isa_pkg::GRP_LD_A_BCDE, z80_isa_pkg::GRP_LD_BCDE_A,
            z80_isa_pkg::GRP_LD_HL_REG: begin
                if (state == z80_isa_pkg::ST_OP) begin
                    next_scratch_addr = o_addr + 16'd1;
                    rp.rd_sel1 = (i_group == z80_isa_pkg::GRP_LD_HL_REG) ? z80_isa_pkg::REG_HL
                                                                         : op_bcde;
                    rp.rd_sel2 = (i_group == z80_isa_pkg::GRP_LD_HL_REG) ? op_src
                                                                         : z80_isa_pkg::REG_A;
                    next_addr       = rp.rd_data1;
                    next_write_mem  = (i_group != z80_isa_pkg::GRP_LD_A_BCDE);
                    next_write_data = rp.rd_data2[7:0];
                end else begin
                    next_addr = scratch_addr;
                    next_done = 1'b1;
                    if (i_group == z80_isa_pkg::GRP_LD_A_BCDE) begin
                        rp.wr_en   = 1'b1;
                        rp.wr_sel  = z80_isa_pkg::REG_A;
                        rp.wr_data = {8'h00, i_mem_data};
                    end
                end
            end
            default: ;
        endcase

        next_read_mem = !next_write_mem; // every non-write step reads
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= z80_isa_pkg::ST_OP;
            o_addr       <= RESET_PC;
            o_read_mem   <= 1'b1;
            o_write_mem  <= 1'b0;
            o_write_data <= '0;
            o_done       <= 1'b1;
        end else begin
            state        <= next_state;
            o_addr       <= next_addr;
            o_read_mem   <= next_read_mem;
            o_write_mem  <= next_write_mem;
            o_write_data <= next_write_data;
            o_done       <= next_done;
        end
    end

    always_ff @(posedge clk) begin
        opcode_q     <= o_opcode;
        scratch_addr <= next_scratch_addr;
        scratch_data <= next_scratch_data;
    end

    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (reset) !(o_read_mem && o_write_mem)
    );

    a_done_at_op: assert property (
        @(posedge clk) disable iff (reset) o_done |-> state == z80_isa_pkg::ST_OP
    );

endmodule

// File: z80_instr_decoder.sv
module z80_instr_decoder (
    input  z80_bus_pkg::byte_t       i_opcode,
    output z80_isa_pkg::insn_group_t o_group
);

    logic [2:0] dst;
    logic [2:0] src;

    assign dst = i_opcode[z80_isa_pkg::OP_DST_HI:z80_isa_pkg::OP_DST_LO];
    assign src = i_opcode[z80_isa_pkg::OP_SRC_HI:z80_isa_pkg::OP_SRC_LO];

    always_comb begin
        o_group = z80_isa_pkg::GRP_NOP;
        case (i_opcode[7:6])
            2'b01: begin
                // src of 6 is LD r,(HL) or HALT, both left as nop
                if (src != z80_isa_pkg::FLD_MEM) begin
                    if (dst == z80_isa_pkg::FLD_MEM)
                        o_group = z80_isa_pkg::GRP_LD_HL_REG;
                    else
                        o_group = z80_isa_pkg::GRP_LD_REG_REG;
                end
            end
            2'b00: begin
                if (src == z80_isa_pkg::FLD_MEM) begin
                    if (dst == z80_isa_pkg::FLD_MEM)
                        o_group = z80_isa_pkg::GRP_LD_HL_IMMED;
                    else
                        o_group = z80_isa_pkg::GRP_LD_REG_IMMED;
                end else if (i_opcode[3:0] == 4'b0001) begin
                    o_group = z80_isa_pkg::GRP_LD_DD_IMMED;
                end else begin
                    case (i_opcode)
                        z80_isa_pkg::OPC_LD_BC_A,
                        z80_isa_pkg::OPC_LD_DE_A: o_group = z80_isa_pkg::GRP_LD_BCDE_A;
                        z80_isa_pkg::OPC_LD_A_BC,
                        z80_isa_pkg::OPC_LD_A_DE: o_group = z80_isa_pkg::GRP_LD_A_BCDE;
                        z80_isa_pkg::OPC_LD_NN_A: o_group = z80_isa_pkg::GRP_LD_EXTADDR_A;
                        z80_isa_pkg::OPC_LD_A_NN: o_group = z80_isa_pkg::GRP_LD_A_EXTADDR;
                        default: ;
                    endcase
                end
            end
            default: ;
        endcase
    end

endmodule

// File: z80_register_file.sv
module z80_register_file (
    input logic    clk,
    input logic    reset,
    reg_port_if.rf rp
);

    z80_bus_pkg::byte_t regs [8]; // B C D E H L - A, slot 6 stays zero
    z80_bus_pkg::word_t sp;

    function automatic z80_bus_pkg::word_t read_sel(z80_isa_pkg::reg_sel_t sel);
        logic [2:0] hi;
        hi = {sel[1:0], 1'b0};
        if (!sel[3])
            return {8'h00, regs[sel[2:0]]};
        if (sel[1:0] == 2'b11)
            return sp;
        return {regs[hi], regs[hi + 3'd1]};
    endfunction

    // both read ports are combinational
    always_comb begin
        rp.rd_data1 = read_sel(rp.rd_sel1);
        rp.rd_data2 = read_sel(rp.rd_sel2);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
            sp <= '0;
        end else if (rp.wr_en) begin
            if (!rp.wr_sel[3]) begin
                regs[rp.wr_sel[2:0]] <= rp.wr_data[7:0];
            end else if (rp.wr_sel[1:0] == 2'b11) begin
                sp <= rp.wr_data;
            end else begin
                regs[{rp.wr_sel[1:0], 1'b0}] <= rp.wr_data[15:8]; // B, D, H
                regs[{rp.wr_sel[1:0], 1'b1}] <= rp.wr_data[7:0];  // C, E, L
            end
        end
    end

    // sequencer must never route an (HL) field into a register write
    a_no_write_slot6: assert property (
        @(posedge clk) disable iff (reset)
        rp.wr_en |-> rp.wr_sel != z80_isa_pkg::REG_NONE
    );

endmodule

// File: reg_port_if.sv
interface reg_port_if;

    z80_isa_pkg::reg_sel_t rd_sel1;
    z80_isa_pkg::reg_sel_t rd_sel2;
    z80_bus_pkg::word_t    rd_data1;
    z80_bus_pkg::word_t    rd_data2;

    logic                  wr_en;
    z80_isa_pkg::reg_sel_t wr_sel;
    z80_bus_pkg::word_t    wr_data;

    modport seq (
        output rd_sel1, rd_sel2, wr_en, wr_sel, wr_data,
        input  rd_data1, rd_data2
    );

    modport rf (
        input  rd_sel1, rd_sel2, wr_en, wr_sel, wr_data,
        output rd_data1, rd_data2
    );

endinterface

// File: z80_isa_pkg.sv
package z80_isa_pkg;

    // 0..7 are 8-bit regs in opcode field order, 8..11 are BC DE HL SP
    typedef logic [3:0] reg_sel_t;

    localparam reg_sel_t REG_NONE = 4'd6; // (HL) slot, no register behind it
    localparam reg_sel_t REG_A    = 4'd7;
    localparam reg_sel_t REG_BC   = 4'd8;
    localparam reg_sel_t REG_DE   = 4'd9;
    localparam reg_sel_t REG_HL   = 4'd10;

    typedef enum logic [3:0] {
        GRP_NOP,
        GRP_LD_REG_REG,
        GRP_LD_REG_IMMED,
        GRP_LD_A_BCDE,
        GRP_LD_BCDE_A,
        GRP_LD_HL_IMMED,
        GRP_LD_HL_REG,
        GRP_LD_DD_IMMED,
        GRP_LD_A_EXTADDR,
        GRP_LD_EXTADDR_A
    } insn_group_t;

    // step counter within one instruction
    typedef enum logic [1:0] {
        ST_OP,
        ST_1,
        ST_2,
        ST_3
    } seq_state_t;

    // opcode bit fields
    localparam int OP_DST_HI = 5;
    localparam int OP_DST_LO = 3;
    localparam int OP_SRC_HI = 2;
    localparam int OP_SRC_LO = 0;
    localparam int OP_DD_HI  = 5;
    localparam int OP_DD_LO  = 4;
    localparam int OP_DE_BIT = 4;       // BC or DE in the indirect A loads

    localparam logic [2:0] FLD_MEM = 3'd6; // r field value meaning (HL)

    localparam logic [7:0] OPC_LD_BC_A = 8'h02;
    localparam logic [7:0] OPC_LD_DE_A = 8'h12;
    localparam logic [7:0] OPC_LD_A_BC = 8'h0A;
    localparam logic [7:0] OPC_LD_A_DE = 8'h1A;
    localparam logic [7:0] OPC_LD_NN_A = 8'h32;
    localparam logic [7:0] OPC_LD_A_NN = 8'h3A;

endpackage

// File: z80_bus_pkg.sv
package z80_bus_pkg;

    // memory address on the bus
    typedef logic [15:0] addr_t;

    // one data byte
    typedef logic [7:0] byte_t;

    // register pair value, high byte first
    typedef logic [15:0] word_t;

endpackage
